/* Makefile */
# Verilator simulation of the always-on peripheral subsystem

TOP := ao_peripheral_subsystem_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for failure"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f ao_peripheral_subsystem.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

/* ao_peripheral_subsystem.f */
verilog/ao_bus_pkg.sv
verilog/ao_map_pkg.sv
verilog/obi_to_reg_bridge.sv
verilog/ao_reg_demux.sv
verilog/soc_ctrl.sv
verilog/fast_intr_ctrl.sv
verilog/ao_timer.sv
verilog/ao_peripheral_subsystem.sv
testbench/ao_peripheral_subsystem_tb.sv

/* testbench/ao_peripheral_subsystem_tb.sv */
// Testbench for the always-on peripheral subsystem
// Drives OBI accesses, models the external register port and checks every response

`timescale 1ns/10ps

module ao_peripheral_subsystem_tb;

  import ao_bus_pkg::*;

  localparam int          TIMEOUT  = 100;
  localparam logic [31:0] SOC_BASE = 32'h2000_0000;
  localparam logic [31:0] FI_BASE  = 32'h2000_1000;
  localparam logic [31:0] TMR_BASE = 32'h2000_2000;
  localparam logic [31:0] EXT_BASE = 32'h2000_3000;

  logic        clk;
  logic        rst_n;
  obi_req_t    slave_req;
  obi_resp_t   slave_resp_o;
  logic        boot_select;
  logic        execute_from_flash;
  logic        exit_valid_o;
  logic [31:0] exit_value_o;
  logic [14:0] fast_intr_i;
  logic [14:0] fast_intr_o;
  logic        timer_0_intr_o;
  logic        timer_1_intr_o;
  reg_req_t    ext_periph_req_o;
  reg_rsp_t    ext_rsp = '0;

  // Shadow of every register and of the external memory
  logic        sh_exit_valid;
  logic [31:0] sh_exit_value;
  logic [14:0] sh_pending;
  logic [14:0] sh_enable;
  logic [31:0] sh_prescale;
  logic [31:0] sh_cmp0;
  logic [31:0] sh_cmp1;
  logic [1:0]  sh_ctrl;
  logic [31:0] sh_ext [1024];

  // Accesses in issue order, consumed by the compare process
  logic [31:0] pend_addr [$];
  logic        pend_we [$];
  string       pend_name [$];
  int          cmp_idx = 0;
  logic [32:0] exp_resp;

  logic [31:0] ext_mem [1024];
  logic        ext_armed;
  int          ext_delay;
  logic [9:0]  widx;

  int          last_latency;
  int          checks = 0;
  int          mismatches = 0;
  int          other_errors = 0;

  ao_peripheral_subsystem dut_i (
    .clk_i                (clk),
    .rst_n_i              (rst_n),
    .slave_req_i          (slave_req),
    .slave_resp_o         (slave_resp_o),
    .boot_select_i        (boot_select),
    .execute_from_flash_i (execute_from_flash),
    .exit_valid_o         (exit_valid_o),
    .exit_value_o         (exit_value_o),
    .fast_intr_i          (fast_intr_i),
    .fast_intr_o          (fast_intr_o),
    .timer_0_intr_o       (timer_0_intr_o),
    .timer_1_intr_o       (timer_1_intr_o),
    .ext_periph_req_o     (ext_periph_req_o),
    .ext_periph_rsp_i     (ext_rsp)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Expected {err, rdata} of a read from the memory map and the shadows
  function automatic logic [32:0] expected_resp(input logic [31:0] addr);
    logic [32:0] resp;
    resp = '0;
    if (addr < SOC_BASE || addr >= EXT_BASE + 32'h1000) begin
      resp = {1'b1, 32'h0};
    end else begin
      case (addr[13:12])
        2'd0: case (addr[11:0])
          12'h000: resp[31:0] = {31'b0, sh_exit_valid};
          12'h004: resp[31:0] = sh_exit_value;
          12'h008: resp[31:0] = {30'b0, execute_from_flash, boot_select};
          default: resp = '0;
        endcase
        2'd1: case (addr[11:0])
          12'h000: resp[31:0] = {17'b0, sh_pending};
          12'h004: resp[31:0] = {17'b0, sh_enable};
          default: resp = '0;
        endcase
        2'd2: case (addr[11:0])
          12'h004: resp[31:0] = sh_prescale;
          12'h008: resp[31:0] = sh_cmp0;
          12'h00C: resp[31:0] = sh_cmp1;
          12'h010: resp[31:0] = {30'b0, sh_ctrl};
          default: resp = '0;
        endcase
        default: resp[31:0] = sh_ext[addr[11:2]];
      endcase
    end
    return resp;
  endfunction

  function automatic void update_shadow(input logic [31:0] addr, input logic [31:0] wdata,
                                        input logic [3:0] be);
    if (addr >= SOC_BASE && addr < EXT_BASE + 32'h1000) begin
      case (addr[13:12])
        2'd0: begin
          if (addr[11:0] == 12'h000 && be[0]) sh_exit_valid = wdata[0];
          if (addr[11:0] == 12'h004) sh_exit_value = merge_bytes(sh_exit_value, wdata, be);
        end
        2'd1: begin
          if (addr[11:0] == 12'h000) sh_pending = sh_pending & ~wdata[14:0];
          if (addr[11:0] == 12'h004) sh_enable = wdata[14:0];
        end
        2'd2: case (addr[11:0])
          12'h004: sh_prescale = wdata;
          12'h008: sh_cmp0 = wdata;
          12'h00C: sh_cmp1 = wdata;
          12'h010: sh_ctrl = wdata[1:0];
          default: ;
        endcase
        default: sh_ext[addr[11:2]] = merge_bytes(sh_ext[addr[11:2]], wdata, be);
      endcase
    end
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      mismatches++;
      $display("CHECK FAILED %s: expected %h, actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic report_counts();
    $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errors);
  endtask

  task automatic abort_run(input string what);
    other_errors++;
    $display("Timeout: %s", what);
    report_counts();
    $display("Test failed");
    $finish;
  endtask

  // One OBI access starting on a falling edge
  task automatic obi_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] be, input string name,
                            output logic [31:0] rdata, output logic err);
    int n;
    n = 0;
    pend_addr.push_back(addr);
    pend_we.push_back(we);
    pend_name.push_back(name);
    slave_req.req   = 1'b1;
    slave_req.we    = we;
    slave_req.be    = be;
    slave_req.addr  = addr;
    slave_req.wdata = wdata;
    #1;
    // The bridge is idle between accesses, so the grant comes at once
    check_value({name, " gnt"}, 32'h1, 32'(slave_resp_o.gnt));
    while (!slave_resp_o.gnt) begin
      if (n == TIMEOUT) abort_run({"no grant for ", name});
      n++;
      @(negedge clk);
    end
    @(negedge clk);
    slave_req = '0;
    n = 1;
    while (!slave_resp_o.rvalid) begin
      if (n == TIMEOUT) abort_run({"no rvalid for ", name});
      n++;
      @(negedge clk);
    end
    last_latency = n;
    rdata = slave_resp_o.rdata;
    err   = slave_resp_o.err;
    if (we) begin
      update_shadow(addr, wdata, be);
    end
  endtask

  task automatic obi_write(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] be, input string name);
    logic [31:0] rdata;
    logic        err;
    obi_access(1'b1, addr, wdata, be, name, rdata, err);
  endtask

  task automatic obi_read(input logic [31:0] addr, input string name,
                          output logic [31:0] rdata);
    logic err;
    obi_access(1'b0, addr, 32'h0, 4'hF, name, rdata, err);
  endtask

  task automatic pulse_fast_intr(input logic [14:0] mask);
    @(negedge clk);
    fast_intr_i = mask;
    @(negedge clk);
    fast_intr_i = '0;
    sh_pending  = sh_pending | mask;
  endtask

  // External register port answering after 0 to 5 wait cycles
  always @(negedge clk) begin
    if (!rst_n) begin
      ext_rsp   = '0;
      ext_armed = 1'b0;
      for (int i = 0; i < 1024; i++) begin
        ext_mem[i] = (32'(i) * 32'h0001_0203) ^ 32'h5A5A_0000;
      end
    end else if (ext_rsp.ready) begin
      ext_rsp   = '0;
      ext_armed = 1'b0;
    end else if (ext_periph_req_o.valid) begin
      if (!ext_armed) begin
        ext_armed = 1'b1;
        ext_delay = $urandom_range(5, 0);
      end
      if (ext_delay == 0) begin
        widx          = ext_periph_req_o.addr[11:2];
        ext_rsp.ready = 1'b1;
        ext_rsp.rdata = ext_mem[widx];
        if (ext_periph_req_o.write) begin
          ext_mem[widx] = merge_bytes(ext_mem[widx], ext_periph_req_o.wdata,
                                      ext_periph_req_o.wstrb);
        end
      end else begin
        ext_delay--;
      end
    end
  end

  // Compare each response with the reference in issue order
  always @(negedge clk) begin
    if (slave_resp_o.rvalid) begin
      if (cmp_idx >= pend_addr.size()) begin
        other_errors++;
        $display("rvalid arrived with no access outstanding at %0t", $time);
      end else begin
        exp_resp = expected_resp(pend_addr[cmp_idx]);
        check_value({pend_name[cmp_idx], " err"}, 32'(exp_resp[32]), 32'(slave_resp_o.err));
        // The running count is checked by range in the timer test
        if (!pend_we[cmp_idx] && pend_addr[cmp_idx] != TMR_BASE) begin
          check_value({pend_name[cmp_idx], " rdata"}, exp_resp[31:0], slave_resp_o.rdata);
        end
        cmp_idx++;
      end
    end
  end

  initial begin
    logic [31:0] rdata;
    logic [31:0] addr;
    logic [31:0] exit_val;
    logic [14:0] mask;
    int          n;
    rst_n       = 1'b0;
    slave_req   = '0;
    fast_intr_i = '0;
    void'($urandom(32'h287df472));
    {execute_from_flash, boot_select} = 2'($urandom);
    sh_exit_valid = 1'b0;
    sh_exit_value = '0;
    sh_pending    = '0;
    sh_enable     = '0;
    sh_prescale   = '0;
    sh_cmp0       = '0;
    sh_cmp1       = '0;
    sh_ctrl       = '0;
    for (int i = 0; i < 1024; i++) begin
      sh_ext[i] = (32'(i) * 32'h0001_0203) ^ 32'h5A5A_0000;
    end
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // SoC control
    exit_val = $urandom;
    obi_write(SOC_BASE + 32'h4, exit_val, 4'hF, "exit value");
    check_value("exit_valid_o before flag", 32'h0, 32'(exit_valid_o));
    check_value("exit_value_o", exit_val, exit_value_o);
    obi_write(SOC_BASE, 32'h1, 4'hF, "exit valid");
    check_value("exit_valid_o", 32'h1, 32'(exit_valid_o));
    obi_read(SOC_BASE + 32'h8, "boot straps", rdata);
    obi_read(SOC_BASE + 32'h4, "exit value readback", rdata);
    obi_read(SOC_BASE + 32'h40, "soc unmapped", rdata);

    // External port under back-pressure
    for (int i = 0; i < 20; i++) begin
      addr = EXT_BASE | ({22'b0, 10'($urandom)} << 2);
      obi_write(addr, $urandom, 4'($urandom), "ext write");
      obi_read(addr, "ext read back", rdata);
      obi_read(EXT_BASE | ({22'b0, 10'($urandom)} << 2), "ext read", rdata);
    end

    // Decode errors
    obi_read(32'h1000_0000, "decode low", rdata);
    check_value("decode low latency", 32'd2, 32'(last_latency));
    obi_read(32'h2000_4000, "decode high", rdata);
    check_value("decode high latency", 32'd2, 32'(last_latency));
    obi_write(32'hFFFF_FFF0, 32'hDEAD_BEEF, 4'hF, "decode write");
    check_value("decode write latency", 32'd2, 32'(last_latency));

    // Fast interrupts
    obi_write(FI_BASE + 32'h4, {17'b0, 15'($urandom)}, 4'hF, "fi enable");
    obi_read(FI_BASE + 32'h4, "fi enable readback", rdata);
    for (int i = 0; i < 4; i++) begin
      pulse_fast_intr(15'($urandom) | 15'h1);
      check_value("fast_intr_o after pulse", 32'(sh_pending & sh_enable), 32'(fast_intr_o));
      obi_read(FI_BASE, "fi pending", rdata);
      mask = sh_pending & 15'($urandom);
      obi_write(FI_BASE, {17'b0, mask}, 4'hF, "fi clear");
      obi_read(FI_BASE, "fi pending after clear", rdata);
      check_value("fast_intr_o after clear", 32'(sh_pending & sh_enable), 32'(fast_intr_o));
    end

    // Timer with compare 1 armed low but left disabled
    obi_write(TMR_BASE + 32'h4, 32'h0, 4'hF, "tmr prescale");
    obi_write(TMR_BASE + 32'h8, 32'd20, 4'hF, "tmr cmp0");
    obi_write(TMR_BASE + 32'hC, 32'd4, 4'hF, "tmr cmp1");
    obi_write(TMR_BASE, 32'h0, 4'hF, "tmr count");
    obi_write(TMR_BASE + 32'h10, 32'h1, 4'hF, "tmr ctrl");
    n = 0;
    while (!timer_0_intr_o) begin
      if (n == TIMEOUT) abort_run("timer_0_intr_o never rose");
      check_value("timer_1_intr_o while disabled", 32'h0, 32'(timer_1_intr_o));
      n++;
      @(negedge clk);
    end
    check_value("timer_1_intr_o while disabled", 32'h0, 32'(timer_1_intr_o));
    obi_read(TMR_BASE, "tmr count", rdata);
    check_value("tmr count at or above cmp0", 32'h1, 32'(rdata >= 32'd20));
    obi_read(TMR_BASE + 32'h4, "tmr prescale readback", rdata);
    obi_read(TMR_BASE + 32'h8, "tmr cmp0 readback", rdata);
    obi_read(TMR_BASE + 32'hC, "tmr cmp1 readback", rdata);
    obi_read(TMR_BASE + 32'h10, "tmr ctrl readback", rdata);
    obi_read(TMR_BASE + 32'h80, "tmr unmapped", rdata);

    repeat (4) @(negedge clk);
    report_counts();
    if (mismatches == 0 && other_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* verilog/ao_bus_pkg.sv */
// Always-on bus types
// OBI slave port and register-bus request/response structs

package ao_bus_pkg;

  // OBI request from the core
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  // OBI response, gnt and rvalid come in separate cycles
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_resp_t;

  // Register-bus request, held until ready
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [3:0]  wstrb;
    logic [31:0] addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        ready;
    logic        error;
    logic [31:0] rdata;
  } reg_rsp_t;

endpackage

/* verilog/ao_map_pkg.sv */
// Always-on address map
// Target windows, target indices and register offsets

package ao_map_pkg;

  localparam logic [31:0] AO_BASE         = 32'h2000_0000;
  localparam int unsigned AO_TARGETS      = 4;
  localparam int unsigned AO_SEL_WIDTH    = 2;
  localparam logic [31:0] AO_TARGET_SPAN  = 32'h0000_1000;
  localparam int unsigned AO_OFFSET_WIDTH = $clog2(AO_TARGET_SPAN);
  localparam logic [31:0] AO_END          = AO_BASE + AO_TARGETS * AO_TARGET_SPAN;

  localparam int unsigned SOC_CTRL_IDX   = 0;
  localparam int unsigned FAST_INTR_IDX  = 1;
  localparam int unsigned TIMER_IDX      = 2;
  localparam int unsigned EXT_PERIPH_IDX = 3;

  // SoC control
  localparam logic [AO_OFFSET_WIDTH-1:0] EXIT_VALID  = 12'h000;
  localparam logic [AO_OFFSET_WIDTH-1:0] EXIT_VALUE  = 12'h004;
  localparam logic [AO_OFFSET_WIDTH-1:0] BOOT_STRAPS = 12'h008;

  // Fast interrupt controller
  localparam logic [AO_OFFSET_WIDTH-1:0] FI_PENDING = 12'h000;
  localparam logic [AO_OFFSET_WIDTH-1:0] FI_ENABLE  = 12'h004;
  localparam int unsigned FAST_INTR_NUM = 15;

  // Timer
  localparam logic [AO_OFFSET_WIDTH-1:0] TMR_COUNT    = 12'h000;
  localparam logic [AO_OFFSET_WIDTH-1:0] TMR_PRESCALE = 12'h004;
  localparam logic [AO_OFFSET_WIDTH-1:0] TMR_CMP0     = 12'h008;
  localparam logic [AO_OFFSET_WIDTH-1:0] TMR_CMP1     = 12'h00C;
  localparam logic [AO_OFFSET_WIDTH-1:0] TMR_CTRL     = 12'h010;
  localparam int unsigned TMR_CTRL_CMP0_EN = 0;
  localparam int unsigned TMR_CTRL_CMP1_EN = 1;

endpackage

/* verilog/ao_peripheral_subsystem.sv */
// Always-on peripheral subsystem
// OBI slave port into SoC control, fast interrupts, timer and an external port

`timescale 1ns/10ps

module ao_peripheral_subsystem (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,

  input  ao_bus_pkg::obi_req_t                 slave_req_i,
  output ao_bus_pkg::obi_resp_t                slave_resp_o,

  input  logic                                 boot_select_i,
  input  logic                                 execute_from_flash_i,
  output logic                                 exit_valid_o,
  output logic [31:0]                          exit_value_o,

  input  logic [ao_map_pkg::FAST_INTR_NUM-1:0] fast_intr_i,
  output logic [ao_map_pkg::FAST_INTR_NUM-1:0] fast_intr_o,

  output logic                                 timer_0_intr_o,
  output logic                                 timer_1_intr_o,

  output ao_bus_pkg::reg_req_t                 ext_periph_req_o,
  input  ao_bus_pkg::reg_rsp_t                 ext_periph_rsp_i
);

  import ao_bus_pkg::*;
  import ao_map_pkg::*;

  reg_req_t                  periph_req;
  reg_rsp_t                  periph_rsp;
  reg_req_t [AO_TARGETS-1:0] tgt_req;
  reg_rsp_t [AO_TARGETS-1:0] tgt_rsp;

  obi_to_reg_bridge bridge_i (
    .clk_i,
    .rst_n_i,
    .obi_req_i  (slave_req_i),
    .obi_resp_o (slave_resp_o),
    .reg_req_o  (periph_req),
    .reg_rsp_i  (periph_rsp)
  );

  ao_reg_demux demux_i (
    .req_i     (periph_req),
    .rsp_o     (periph_rsp),
    .tgt_req_o (tgt_req),
    .tgt_rsp_i (tgt_rsp)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i (tgt_req[SOC_CTRL_IDX]),
    .reg_rsp_o (tgt_rsp[SOC_CTRL_IDX]),
    .boot_select_i,
    .execute_from_flash_i,
    .exit_valid_o,
    .exit_value_o
  );

  fast_intr_ctrl fast_intr_ctrl_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i (tgt_req[FAST_INTR_IDX]),
    .reg_rsp_o (tgt_rsp[FAST_INTR_IDX]),
    .fast_intr_i,
    .fast_intr_o
  );

  ao_timer timer_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i (tgt_req[TIMER_IDX]),
    .reg_rsp_o (tgt_rsp[TIMER_IDX]),
    .timer_0_intr_o,
    .timer_1_intr_o
  );

  // External window leaves the subsystem as is
  assign ext_periph_req_o        = tgt_req[EXT_PERIPH_IDX];
  assign tgt_rsp[EXT_PERIPH_IDX] = ext_periph_rsp_i;

endmodule

/* verilog/ao_reg_demux.sv */
// Register-bus address decoder and demultiplexer
// Routes one request to the always-on targets, answers misses with an error

`timescale 1ns/10ps

module ao_reg_demux (
  input  ao_bus_pkg::reg_req_t                            req_i,
  output ao_bus_pkg::reg_rsp_t                            rsp_o,
  output ao_bus_pkg::reg_req_t [ao_map_pkg::AO_TARGETS-1:0] tgt_req_o,
  input  ao_bus_pkg::reg_rsp_t [ao_map_pkg::AO_TARGETS-1:0] tgt_rsp_i
);

  import ao_map_pkg::*;

  logic                    hit;
  logic [AO_SEL_WIDTH-1:0] sel;
  logic [AO_TARGETS-1:0]   tgt_valid;

  // Windows are contiguous, so the index is just the bits above the offset
  assign hit = (req_i.addr >= AO_BASE) && (req_i.addr < AO_END);
  assign sel = req_i.addr[AO_OFFSET_WIDTH +: AO_SEL_WIDTH];

  always_comb begin
    for (int i = 0; i < AO_TARGETS; i++) begin
      tgt_req_o[i]       = req_i;
      tgt_req_o[i].valid = req_i.valid && hit && (sel == AO_SEL_WIDTH'(i));
      tgt_valid[i]       = tgt_req_o[i].valid;
    end
  end

  always_comb begin
    if (hit) begin
      rsp_o = tgt_rsp_i[sel];
    end else begin
      // Decode error, answered here without wait
      rsp_o.ready = 1'b1;
      rsp_o.error = 1'b1;
      rsp_o.rdata = '0;
    end
  end

  // Fan-out must never address two targets at once
  always_comb begin
    one_target_a: assert ($onehot0(tgt_valid))
      else $error("more than one target selected");
  end

endmodule

/* verilog/ao_timer.sv */
// Always-on timer
// Prescaled 32-bit counter with two compare interrupts

`timescale 1ns/10ps

module ao_timer (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  ao_bus_pkg::reg_req_t reg_req_i,
  output ao_bus_pkg::reg_rsp_t reg_rsp_o,
  output logic                 timer_0_intr_o,
  output logic                 timer_1_intr_o
);

  import ao_map_pkg::*;

  logic [AO_OFFSET_WIDTH-1:0] offset;
  logic                       wr_en;
  logic                       tick;
  logic [31:0]                presc_cnt_q;
  logic [31:0]                prescale_q;
  logic [31:0]                count_q;
  logic [31:0]                cmp0_q;
  logic [31:0]                cmp1_q;
  logic [1:0]                 ctrl_d;
  logic [1:0]                 ctrl_q;
  logic                       intr0_q;
  logic                       intr1_q;

  assign offset = reg_req_i.addr[AO_OFFSET_WIDTH-1:0];
  assign wr_en  = reg_req_i.valid && reg_req_i.write;

  // One count step per (prescale + 1) cycles
  assign tick   = (presc_cnt_q >= prescale_q);
  assign ctrl_d = (wr_en && offset == TMR_CTRL) ? reg_req_i.wdata[1:0] : ctrl_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      presc_cnt_q <= '0;
      prescale_q  <= '0;
      count_q     <= '0;
      cmp0_q      <= '0;
      cmp1_q      <= '0;
      ctrl_q      <= '0;
      intr0_q     <= 1'b0;
      intr1_q     <= 1'b0;
    end else begin
      presc_cnt_q <= tick ? '0 : presc_cnt_q + 32'd1;
      ctrl_q      <= ctrl_d;
      if (wr_en && offset == TMR_COUNT) begin
        count_q <= reg_req_i.wdata;
      end else if (tick) begin
        count_q <= count_q + 32'd1;
      end
      if (wr_en && offset == TMR_PRESCALE) prescale_q <= reg_req_i.wdata;
      if (wr_en && offset == TMR_CMP0) cmp0_q <= reg_req_i.wdata;
      if (wr_en && offset == TMR_CMP1) cmp1_q <= reg_req_i.wdata;
      // Level interrupts, dropped as soon as the enable goes away
      intr0_q <= ctrl_d[TMR_CTRL_CMP0_EN] && (count_q >= cmp0_q);
      intr1_q <= ctrl_d[TMR_CTRL_CMP1_EN] && (count_q >= cmp1_q);
    end
  end

  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b0;
    case (offset)
      TMR_COUNT:    reg_rsp_o.rdata = count_q;
      TMR_PRESCALE: reg_rsp_o.rdata = prescale_q;
      TMR_CMP0:     reg_rsp_o.rdata = cmp0_q;
      TMR_CMP1:     reg_rsp_o.rdata = cmp1_q;
      TMR_CTRL:     reg_rsp_o.rdata = {30'b0, ctrl_q};
      default:      reg_rsp_o.rdata = '0;
    endcase
  end

  assign timer_0_intr_o = intr0_q;
  assign timer_1_intr_o = intr1_q;

  intr0_en_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    timer_0_intr_o |-> ctrl_q[TMR_CTRL_CMP0_EN]);
  intr1_en_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    timer_1_intr_o |-> ctrl_q[TMR_CTRL_CMP1_EN]);

endmodule

/* verilog/fast_intr_ctrl.sv */
// Fast interrupt controller
// Latches interrupt pulses as pending and masks them with an enable register

`timescale 1ns/10ps

module fast_intr_ctrl (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  ao_bus_pkg::reg_req_t                reg_req_i,
  output ao_bus_pkg::reg_rsp_t                reg_rsp_o,
  input  logic [ao_map_pkg::FAST_INTR_NUM-1:0] fast_intr_i,
  output logic [ao_map_pkg::FAST_INTR_NUM-1:0] fast_intr_o
);

  import ao_map_pkg::*;

  logic [AO_OFFSET_WIDTH-1:0] offset;
  logic                       wr_en;
  logic [FAST_INTR_NUM-1:0]   clr;
  logic [FAST_INTR_NUM-1:0]   pending_d;
  logic [FAST_INTR_NUM-1:0]   pending_q;
  logic [FAST_INTR_NUM-1:0]   enable_d;
  logic [FAST_INTR_NUM-1:0]   enable_q;
  logic [FAST_INTR_NUM-1:0]   intr_q;

  assign offset = reg_req_i.addr[AO_OFFSET_WIDTH-1:0];
  assign wr_en  = reg_req_i.valid && reg_req_i.write;

  // Write one to clear, a new pulse in the same cycle wins
  assign clr       = (wr_en && offset == FI_PENDING) ? reg_req_i.wdata[FAST_INTR_NUM-1:0] : '0;
  assign pending_d = (pending_q & ~clr) | fast_intr_i;
  assign enable_d  = (wr_en && offset == FI_ENABLE) ? reg_req_i.wdata[FAST_INTR_NUM-1:0]
                                                    : enable_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
      intr_q    <= '0;
    end else begin
      pending_q <= pending_d;
      enable_q  <= enable_d;
      intr_q    <= pending_d & enable_d;
    end
  end

  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b0;
    case (offset)
      FI_PENDING: reg_rsp_o.rdata = {{(32 - FAST_INTR_NUM){1'b0}}, pending_q};
      FI_ENABLE:  reg_rsp_o.rdata = {{(32 - FAST_INTR_NUM){1'b0}}, enable_q};
      default:    reg_rsp_o.rdata = '0;
    endcase
  end

  assign fast_intr_o = intr_q;

endmodule

/* verilog/obi_to_reg_bridge.sv */
// OBI to register-bus bridge
// Takes one OBI access at a time and replays it on the register bus

`timescale 1ns/10ps

module obi_to_reg_bridge (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  ao_bus_pkg::obi_req_t  obi_req_i,
  output ao_bus_pkg::obi_resp_t obi_resp_o,
  output ao_bus_pkg::reg_req_t  reg_req_o,
  input  ao_bus_pkg::reg_rsp_t  reg_rsp_i
);

  import ao_bus_pkg::*;

  typedef enum logic {IDLE, BUSY} state_e;

  state_e      state_q;
  obi_req_t    obi_q;
  logic        gnt;
  logic        rvalid_q;
  logic        err_q;
  logic [31:0] rdata_q;

  // Grant only when nothing is outstanding
  assign gnt = obi_req_i.req && (state_q == IDLE);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= IDLE;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= 1'b0;
      if (gnt) begin
        state_q <= BUSY;
      end else if (state_q == BUSY && reg_rsp_i.ready) begin
        state_q  <= IDLE;
        rvalid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt) begin
      obi_q <= obi_req_i;
    end
    if (state_q == BUSY && reg_rsp_i.ready) begin
      rdata_q <= reg_rsp_i.rdata;
      err_q   <= reg_rsp_i.error;
    end
  end

  always_comb begin
    reg_req_o.valid = (state_q == BUSY);
    reg_req_o.write = obi_q.we;
    reg_req_o.wstrb = obi_q.be;
    reg_req_o.addr  = obi_q.addr;
    reg_req_o.wdata = obi_q.wdata;

    obi_resp_o.gnt    = gnt;
    obi_resp_o.rvalid = rvalid_q;
    obi_resp_o.err    = err_q;
    obi_resp_o.rdata  = rdata_q;
  end

  req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    reg_req_o.valid && !reg_rsp_i.ready |=> $stable(reg_req_o))
    else $error("register request changed while waiting for ready");

endmodule

/* verilog/soc_ctrl.sv */
// SoC control registers
// Exit value and exit flag for the software, boot strap readback

`timescale 1ns/10ps

module soc_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  ao_bus_pkg::reg_req_t reg_req_i,
  output ao_bus_pkg::reg_rsp_t reg_rsp_o,
  input  logic                 boot_select_i,
  input  logic                 execute_from_flash_i,
  output logic                 exit_valid_o,
  output logic [31:0]          exit_value_o
);

  import ao_map_pkg::*;

  logic [AO_OFFSET_WIDTH-1:0] offset;
  logic                       wr_en;
  logic                       exit_valid_q;
  logic [31:0]                exit_value_q;

  assign offset = reg_req_i.addr[AO_OFFSET_WIDTH-1:0];
  assign wr_en  = reg_req_i.valid && reg_req_i.write;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else if (wr_en) begin
      if (offset == EXIT_VALID && reg_req_i.wstrb[0]) begin
        exit_valid_q <= reg_req_i.wdata[0];
      end
      if (offset == EXIT_VALUE) begin
        for (int b = 0; b < 4; b++) begin
          if (reg_req_i.wstrb[b]) begin
            exit_value_q[8*b +: 8] <= reg_req_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b0;
    case (offset)
      EXIT_VALID:  reg_rsp_o.rdata = {31'b0, exit_valid_q};
      EXIT_VALUE:  reg_rsp_o.rdata = exit_value_q;
      BOOT_STRAPS: reg_rsp_o.rdata = {30'b0, execute_from_flash_i, boot_select_i};
      default:     reg_rsp_o.rdata = '0;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule
